/* mips_cfg.svh */
// mips core configuration
`ifndef MIPS_CFG_SVH
`define MIPS_CFG_SVH

// data path and address width
`define MIPS_WORD_W 32

// architectural register count
`define MIPS_NUM_REGS 32

// first fetch address once reset is released
`define MIPS_RESET_VECTOR 32'hBFC00000

// v0 holds function results, mirrored on reg_v0 for debug
`define MIPS_V0_REG 2

`endif

/* mips_pkg.sv */
// mips core types and encodings
`include "mips_cfg.svh"

package mips_pkg;

  typedef logic [`MIPS_WORD_W-1:0] word_t;  // data word or byte address
  typedef logic [4:0]              reg_addr_t;
  typedef logic [5:0]              opcode_t;   // instr[31:26]
  typedef logic [5:0]              funct_t;    // instr[5:0], r-type only
  typedef logic [2:0]              alu_ctrl_t;

  // primary opcodes
  localparam opcode_t op_rtype = 6'h00;
  localparam opcode_t op_j     = 6'h02;
  localparam opcode_t op_beq   = 6'h04;
  localparam opcode_t op_addiu = 6'h09;
  localparam opcode_t op_lui   = 6'h0f;
  localparam opcode_t op_lw    = 6'h23;
  localparam opcode_t op_sw    = 6'h2b;

  // r-type function codes
  localparam funct_t fn_jr   = 6'h08;
  localparam funct_t fn_addu = 6'h21;
  localparam funct_t fn_subu = 6'h23;
  localparam funct_t fn_and  = 6'h24;
  localparam funct_t fn_or   = 6'h25;
  localparam funct_t fn_slt  = 6'h2a;

  // alu operation select
  localparam alu_ctrl_t alu_add = 3'd0;
  localparam alu_ctrl_t alu_sub = 3'd1;
  localparam alu_ctrl_t alu_and = 3'd2;
  localparam alu_ctrl_t alu_or  = 3'd3;
  localparam alu_ctrl_t alu_slt = 3'd4;

  // per-instruction control, all zero means no-op
  typedef struct packed {
    logic      reg_we;       // write a register this cycle
    logic      reg_dst_rd;   // destination is rd, else rt
    logic      alu_src_imm;  // alu b from sign extended immediate
    logic      imm_upper;    // writeback the lui value
    logic      mem_to_reg;   // writeback load data
    logic      mem_we;       // store word
    logic      branch;       // beq, taken on alu zero
    logic      jump;         // j with 26-bit target
    logic      jump_reg;     // jr, next pc from rs
    alu_ctrl_t alu_ctrl;
  } ctrl_t;

endpackage

/* reg_file.sv */
// three port register file
`timescale 1ns/1ps
`include "mips_cfg.svh"

module reg_file import mips_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  logic      we,      // already qualified by stall and halt
  input  reg_addr_t ra1,     // rs
  input  reg_addr_t ra2,     // rt
  input  reg_addr_t wa,
  input  word_t     wd,
  output word_t     rd1,
  output word_t     rd2,
  output word_t     reg_v0   // debug copy of v0
);

  word_t rf [`MIPS_NUM_REGS];

  // one write port, written on the rising edge
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `MIPS_NUM_REGS; i++) begin
        rf[i] <= '0;  // whole file starts clean
      end
    end else if (we && wa != '0) begin
      rf[wa] <= wd;  // writes to $zero are dropped
    end
  end

  // combinational reads
  assign rd1 = rf[ra1];
  assign rd2 = rf[ra2];

  assign reg_v0 = rf[`MIPS_V0_REG];  // debug tap on v0

  // $zero on port 1 must read zero even right after a write to it
  a_zero_reads_zero: assert property (
    @(posedge clk) disable iff (reset)
    (ra1 == '0) |-> (rd1 == '0)
  );

endmodule

/* pc_reg.sv */
// program counter with boot vector
`timescale 1ns/1ps
`include "mips_cfg.svh"

module pc_reg import mips_pkg::*; (
  input  logic  clk,
  input  logic  reset,
  input  logic  en,      // global stall, low holds everything
  input  word_t d,       // next pc from datapath
  output word_t q,       // current fetch address
  output logic  active   // high from boot until a jump to zero
);

  logic boot;  // set during reset, first enabled edge consumes it

  always_ff @(posedge clk) begin
    if (reset) begin
      q      <= '0;  // fetch address reads zero while in reset
      active <= 1'b0;
      boot   <= 1'b1;
    end else if (en) begin
      if (boot) begin
        q      <= `MIPS_RESET_VECTOR;  // boot fetch ignores d
        active <= 1'b1;
        boot   <= 1'b0;
      end else if (active) begin
        q <= d;
        if (d == '0) begin
          active <= 1'b0;  // halt, pc parks at zero until reset
        end
      end
    end
  end

  // every fetch while running is word aligned
  a_pc_aligned: assert property (
    @(posedge clk) disable iff (reset)
    active |-> (q[1:0] == 2'b00)
  );

endmodule

/* control_decoder.sv */
// main instruction decoder
`timescale 1ns/1ps

module control_decoder import mips_pkg::*; (
  input  opcode_t opcode,
  input  funct_t  funct,
  output ctrl_t   ctrl
);

  always_comb begin
    ctrl = '0;  // unknown encodings fall through as no-ops
    case (opcode)
      op_rtype: begin
        // r-type writes rd, operands both from registers
        case (funct)
          fn_addu: begin
            ctrl.reg_we     = 1'b1;
            ctrl.reg_dst_rd = 1'b1;
            ctrl.alu_ctrl   = alu_add;
          end
          fn_subu: begin
            ctrl.reg_we     = 1'b1;
            ctrl.reg_dst_rd = 1'b1;
            ctrl.alu_ctrl   = alu_sub;
          end
          fn_and: begin
            ctrl.reg_we     = 1'b1;
            ctrl.reg_dst_rd = 1'b1;
            ctrl.alu_ctrl   = alu_and;
          end
          fn_or: begin
            ctrl.reg_we     = 1'b1;
            ctrl.reg_dst_rd = 1'b1;
            ctrl.alu_ctrl   = alu_or;
          end
          fn_slt: begin
            ctrl.reg_we     = 1'b1;
            ctrl.reg_dst_rd = 1'b1;
            ctrl.alu_ctrl   = alu_slt;
          end
          fn_jr:   ctrl.jump_reg = 1'b1;  // no writeback
          default: ctrl = '0;
        endcase
      end
      op_addiu: begin
        ctrl.reg_we      = 1'b1;
        ctrl.alu_src_imm = 1'b1;
        ctrl.alu_ctrl    = alu_add;  // no overflow trap
      end
      op_lui: begin
        ctrl.reg_we    = 1'b1;
        ctrl.imm_upper = 1'b1;  // alu result unused
      end
      op_lw: begin
        ctrl.reg_we      = 1'b1;
        ctrl.alu_src_imm = 1'b1;  // base + offset
        ctrl.mem_to_reg  = 1'b1;
        ctrl.alu_ctrl    = alu_add;
      end
      op_sw: begin
        ctrl.alu_src_imm = 1'b1;
        ctrl.mem_we      = 1'b1;
        ctrl.alu_ctrl    = alu_add;
      end
      op_beq: begin
        ctrl.branch   = 1'b1;
        ctrl.alu_ctrl = alu_sub;  // equal when difference is zero
      end
      op_j:    ctrl.jump = 1'b1;
      default: ctrl = '0;
    endcase
  end

endmodule

/* alu.sv */
// integer alu
`timescale 1ns/1ps

module alu import mips_pkg::*; (
  input  word_t     a,
  input  word_t     b,
  input  alu_ctrl_t op,
  output word_t     y,
  output logic      zero  // result is zero, beq condition
);

  logic lt;  // signed a < b

  assign lt = ($signed(a) < $signed(b));

  always_comb begin
    case (op)
      alu_add: y = a + b;  // wraps, addu/addiu semantics
      alu_sub: y = a - b;
      alu_and: y = a & b;
      alu_or:  y = a | b;
      alu_slt: y = word_t'(lt);  // zero extended single bit
      default: y = '0;
    endcase
  end

  assign zero = (y == '0);

endmodule

/* datapath.sv */
// single cycle datapath
`timescale 1ns/1ps
`include "mips_cfg.svh"

module datapath import mips_pkg::*; (
  input  logic  clk,
  input  logic  reset,
  input  logic  clk_enable,  // low stalls the whole core
  input  ctrl_t ctrl,
  input  word_t instr,
  input  word_t mem_rdata,
  output word_t instr_addr,
  output word_t mem_addr,
  output word_t mem_wdata,
  output logic  mem_we,      // one cycle strobe, memory writes on the next edge
  output logic  active,
  output word_t reg_v0
);

  // instruction fields
  reg_addr_t   rs;
  reg_addr_t   rt;
  reg_addr_t   rd;
  logic [15:0] imm;
  logic [25:0] target;

  word_t pc;
  word_t pc_plus4;
  word_t pc_next;
  word_t br_target;
  word_t j_target;
  word_t imm_sext;
  word_t imm_lui;
  word_t rd1;
  word_t rd2;
  word_t alu_b;
  word_t alu_y;
  word_t wd;
  reg_addr_t wa;
  logic  alu_zero;
  logic  commit;   // this edge retires the current instruction
  logic  reg_we;

  assign rs     = instr[25:21];
  assign rt     = instr[20:16];
  assign rd     = instr[15:11];
  assign imm    = instr[15:0];
  assign target = instr[25:0];

  assign imm_sext = {{(`MIPS_WORD_W-16){imm[15]}}, imm};
  assign imm_lui  = {imm, 16'h0000};  // lui places immediate in upper half

  // side effects only while running and not stalled
  assign commit = clk_enable & active;
  assign reg_we = ctrl.reg_we & commit;
  assign mem_we = ctrl.mem_we & commit;

  // pc gating on active happens inside pc_reg so the boot edge can still load
  pc_reg u_pc (
    .clk    (clk),
    .reset  (reset),
    .en     (clk_enable),
    .d      (pc_next),
    .q      (pc),
    .active (active)
  );

  assign wa = ctrl.reg_dst_rd ? rd : rt;

  reg_file u_rf (
    .clk    (clk),
    .reset  (reset),
    .we     (reg_we),
    .ra1    (rs),
    .ra2    (rt),
    .wa     (wa),
    .wd     (wd),
    .rd1    (rd1),
    .rd2    (rd2),
    .reg_v0 (reg_v0)
  );

  assign alu_b = ctrl.alu_src_imm ? imm_sext : rd2;

  alu u_alu (
    .a    (rd1),
    .b    (alu_b),
    .op   (ctrl.alu_ctrl),
    .y    (alu_y),
    .zero (alu_zero)
  );

  // writeback priority lui, then load, then alu
  assign wd = ctrl.imm_upper  ? imm_lui   :
              ctrl.mem_to_reg ? mem_rdata : alu_y;

  assign mem_addr  = alu_y;  // base + offset
  assign mem_wdata = rd2;    // sw stores rt

  // next pc, no delay slot
  assign pc_plus4  = pc + word_t'(4);
  assign br_target = pc_plus4 + {imm_sext[`MIPS_WORD_W-3:0], 2'b00};
  assign j_target  = {pc_plus4[`MIPS_WORD_W-1 -: 4], target, 2'b00};

  assign pc_next = ctrl.jump_reg            ? rd1       :
                   ctrl.jump                ? j_target  :
                   (ctrl.branch & alu_zero) ? br_target : pc_plus4;

  assign instr_addr = pc;

  // active is low through reset so no store can leak out
  a_no_store_in_reset: assert property (
    @(posedge clk) reset |-> !mem_we
  );

endmodule

/* mips_cpu.sv */
// single cycle mips core top
`timescale 1ns/1ps

module mips_cpu import mips_pkg::*; (
  input  logic  clk,
  input  logic  reset,
  input  logic  clk_enable,  // global stall
  output word_t instr_addr,  // fetch address, combinational instruction return
  input  word_t instr,
  output word_t mem_addr,
  output word_t mem_wdata,
  output logic  mem_we,
  input  word_t mem_rdata,   // combinational load data
  output logic  active,      // falls after a jump to zero
  output word_t reg_v0
);

  ctrl_t ctrl;  // decoded control for the current instruction

  control_decoder u_dec (
    .opcode (instr[31:26]),
    .funct  (instr[5:0]),
    .ctrl   (ctrl)
  );

  datapath u_dp (
    .clk        (clk),
    .reset      (reset),
    .clk_enable (clk_enable),
    .ctrl       (ctrl),
    .instr      (instr),
    .mem_rdata  (mem_rdata),
    .instr_addr (instr_addr),
    .mem_addr   (mem_addr),
    .mem_wdata  (mem_wdata),
    .mem_we     (mem_we),
    .active     (active),
    .reg_v0     (reg_v0)
  );

endmodule

/* tb_mips_cpu.sv */
// mips core testbench
`timescale 1ns/1ps
`include "mips_cfg.svh"

module tb_mips_cpu;

  localparam int max_cycles = 200;  // ~22 instrs plus stalls, with wide margin

  // register numbers used by the program
  localparam logic [4:0] r_zero = 5'd0;
  localparam logic [4:0] r_v0   = 5'(`MIPS_V0_REG);
  localparam logic [4:0] r_t0   = 5'd8;
  localparam logic [4:0] r_t1   = 5'd9;
  localparam logic [4:0] r_t2   = 5'd10;

  // fetched outside the program, a poison store only a running core may issue
  localparam logic [31:0] idle_instr = {6'h2b, r_zero, r_t0, 16'd56};

  localparam logic [15:0] lui_imm = 16'h1234;
  localparam logic [15:0] lo_imm  = 16'h8765;  // negative, exercises sign extension

  logic        clk;
  logic        reset;
  logic        clk_enable;
  logic [31:0] instr;
  logic [31:0] instr_addr;
  logic [31:0] mem_addr;
  logic [31:0] mem_wdata;
  logic [31:0] mem_rdata;
  logic        mem_we;
  logic        active;
  logic [31:0] reg_v0;

  logic [31:0] imem [0:31];
  logic [31:0] dmem [0:31];
  logic [31:0] exp_dmem [0:31];  // expected store data, words 8 to 13
  logic [31:0] fetch_off;
  logic [31:0] w0;               // shadow of the random data words
  logic [31:0] w1;
  logic [31:0] exp_v0;
  logic [31:0] j_dest;           // byte address the j lands on
  logic [31:0] exp_pc_q;         // next pc predicted at the last edge
  logic [31:0] addr_q;           // fetch address at the last edge
  logic [31:0] stored;           // words that have seen a store
  logic        enabled_q;        // last edge retired an instruction
  logic        stall_q;          // last edge was a stall while running
  logic        ran;              // core has been active at least once
  int          cyc;
  int          seed_ret;
  int          stall_len;

  mips_cpu uut (
    .clk        (clk),
    .reset      (reset),
    .clk_enable (clk_enable),
    .instr_addr (instr_addr),
    .instr      (instr),
    .mem_addr   (mem_addr),
    .mem_wdata  (mem_wdata),
    .mem_we     (mem_we),
    .mem_rdata  (mem_rdata),
    .active     (active),
    .reg_v0     (reg_v0)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  // instruction encoders
  function automatic logic [31:0] enc_r(input logic [4:0] rs, input logic [4:0] rt,
                                        input logic [4:0] rd, input logic [5:0] fn);
    enc_r = {6'h00, rs, rt, rd, 5'd0, fn};
  endfunction

  function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rs,
                                        input logic [4:0] rt, input logic [15:0] imm);
    enc_i = {op, rs, rt, imm};
  endfunction

  function automatic logic [31:0] addr_of(input int idx);
    addr_of = `MIPS_RESET_VECTOR + (32'(idx) << 2);
  endfunction

  // program flow, only the taken beq, the j and the jr leave the straight line
  function automatic logic [31:0] next_pc_of(input logic [31:0] pc);
    if (pc == addr_of(17)) next_pc_of = addr_of(19);
    else if (pc == addr_of(19)) next_pc_of = addr_of(21);
    else if (pc == addr_of(21)) next_pc_of = 32'd0;  // jr $zero
    else next_pc_of = pc + 32'd4;
  endfunction

  task automatic stop_with_failure();
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic abort_run(input string why);
    $display("%s at %0t", why, $time);
    stop_with_failure();
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] exp_v,
                                 input logic [31:0] got);
    $display("Mismatch at %0t: %s expected %h got %h", $time, name, exp_v, got);
    stop_with_failure();
  endtask

  // memory models, combinational reads
  assign fetch_off = instr_addr - `MIPS_RESET_VECTOR;
  assign instr     = (fetch_off < 32'd128) ? imem[fetch_off[6:2]] : idle_instr;
  assign mem_rdata = dmem[mem_addr[6:2]];

  always @(posedge clk) begin
    if (mem_we) begin
      dmem[mem_addr[6:2]]   <= mem_wdata;
      stored[mem_addr[6:2]] <= 1'b1;
    end
    exp_pc_q  <= next_pc_of(instr_addr);
    enabled_q <= active && clk_enable;
    stall_q   <= !clk_enable && ran;
    addr_q    <= instr_addr;
    ran       <= ran | active;
    cyc       <= cyc + 1;
  end

  always @(posedge clk) begin
    if (cyc >= max_cycles) abort_run("Timeout, core never halted");
  end

  a_reset_mem_we: assert property (@(posedge clk) (reset && cyc > 0) |-> !mem_we)
    else report_mismatch("mem_we", 32'd0, 32'($sampled(mem_we)));
  a_reset_active: assert property (@(posedge clk) (reset && cyc > 0) |-> !active)
    else report_mismatch("active", 32'd0, 32'($sampled(active)));
  a_boot_fetch: assert property (@(posedge clk)
    (!reset && $past(reset) && clk_enable) |=> (instr_addr == `MIPS_RESET_VECTOR))
    else report_mismatch("instr_addr", `MIPS_RESET_VECTOR, $sampled(instr_addr));
  a_next_pc: assert property (@(posedge clk) enabled_q |-> (instr_addr == exp_pc_q))
    else report_mismatch("instr_addr", $sampled(exp_pc_q), $sampled(instr_addr));
  a_stall_hold: assert property (@(posedge clk) stall_q |-> (instr_addr == addr_q))
    else report_mismatch("instr_addr", $sampled(addr_q), $sampled(instr_addr));
  a_stall_no_store: assert property (@(posedge clk) (!clk_enable && cyc > 0) |-> !mem_we)
    else report_mismatch("mem_we", 32'd0, 32'($sampled(mem_we)));
  a_store_addr: assert property (@(posedge clk)
    mem_we |-> (mem_addr >= 32'd32 && mem_addr <= 32'd52 && mem_addr[1:0] == 2'b00))
    else abort_run("Store to an address outside words 8 to 13");
  a_store_data: assert property (@(posedge clk)
    mem_we |-> (mem_wdata == exp_dmem[mem_addr[6:2]]))
    else report_mismatch("mem_wdata", exp_dmem[$sampled(mem_addr[6:2])], $sampled(mem_wdata));
  a_v0_const: assert property (@(posedge clk)
    (active && instr_addr == addr_of(16)) |-> (reg_v0 == exp_v0))
    else report_mismatch("reg_v0", exp_v0, $sampled(reg_v0));
  a_halt_pc: assert property (@(posedge clk) (ran && !active) |-> (instr_addr == 32'd0))
    else report_mismatch("instr_addr", 32'd0, $sampled(instr_addr));
  a_halt_no_store: assert property (@(posedge clk) (ran && !active) |-> !mem_we)
    else report_mismatch("mem_we", 32'd0, 32'($sampled(mem_we)));

  initial begin
    reset      = 1'b1;
    clk_enable = 1'b1;
    cyc        = 0;
    ran        = 1'b0;
    stored     = '0;
    enabled_q  = 1'b0;
    stall_q    = 1'b0;
    exp_pc_q   = '0;
    addr_q     = '0;
    seed_ret   = $urandom(32'h77ea13a6);

    for (int i = 0; i < 32; i++) begin
      dmem[i]     = (i < 8) ? $urandom : (32'hc0de0000 | 32'(i));
      exp_dmem[i] = 32'hffffffff;  // no store expected here
      imem[i]     = 32'd0;         // nop
    end
    w0 = dmem[0];
    w1 = dmem[1];

    // expected results from the two random words
    exp_dmem[8]  = w0 + w1;
    exp_dmem[9]  = w0 - w1;
    exp_dmem[10] = w0 & w1;
    exp_dmem[11] = w0 | w1;
    exp_dmem[12] = ($signed(w0) < $signed(w1)) ? 32'd1 : 32'd0;
    exp_dmem[13] = 32'd0;  // $zero survives the addiu to it
    exp_v0 = {lui_imm, 16'h0000} + {{16{lo_imm[15]}}, lo_imm};
    j_dest = addr_of(21);

    imem[0]  = enc_i(6'h23, r_zero, r_t0, 16'd0);     // lw t0, 0
    imem[1]  = enc_i(6'h23, r_zero, r_t1, 16'd4);     // lw t1, 4
    imem[2]  = enc_r(r_t0, r_t1, r_t2, 6'h21);        // addu
    imem[3]  = enc_i(6'h2b, r_zero, r_t2, 16'd32);
    imem[4]  = enc_r(r_t0, r_t1, r_t2, 6'h23);        // subu
    imem[5]  = enc_i(6'h2b, r_zero, r_t2, 16'd36);
    imem[6]  = enc_r(r_t0, r_t1, r_t2, 6'h24);        // and
    imem[7]  = enc_i(6'h2b, r_zero, r_t2, 16'd40);
    imem[8]  = enc_r(r_t0, r_t1, r_t2, 6'h25);        // or
    imem[9]  = enc_i(6'h2b, r_zero, r_t2, 16'd44);
    imem[10] = enc_r(r_t0, r_t1, r_t2, 6'h2a);        // slt
    imem[11] = enc_i(6'h2b, r_zero, r_t2, 16'd48);
    imem[12] = enc_i(6'h09, r_zero, r_zero, 16'h1234); // addiu into $zero
    imem[13] = enc_i(6'h2b, r_zero, r_zero, 16'd52);
    imem[14] = enc_i(6'h0f, r_zero, r_v0, lui_imm);   // lui v0
    imem[15] = enc_i(6'h09, r_v0, r_v0, lo_imm);      // addiu v0
    imem[16] = enc_i(6'h04, r_zero, r_v0, 16'd3);     // not taken, would hit poison
    imem[17] = enc_i(6'h04, r_zero, r_zero, 16'd1);   // taken over next word
    imem[18] = enc_i(6'h2b, r_zero, r_t0, 16'd56);    // poison
    imem[19] = {6'h02, j_dest[27:2]};                 // j
    imem[20] = enc_i(6'h2b, r_zero, r_t0, 16'd60);    // poison
    imem[21] = enc_r(r_zero, r_zero, r_zero, 6'h08);  // jr $zero

    repeat (5) @(posedge clk);
    reset <= 1'b0;

    // two random stalls while the program runs
    repeat (6) @(posedge clk);
    stall_len = 2 + int'($urandom % 3);
    clk_enable <= 1'b0;
    repeat (stall_len) @(posedge clk);
    clk_enable <= 1'b1;
    repeat (8) @(posedge clk);
    stall_len = 2 + int'($urandom % 3);
    clk_enable <= 1'b0;
    repeat (stall_len) @(posedge clk);
    clk_enable <= 1'b1;

    wait (ran && !active);
    repeat (4) @(posedge clk);  // halted core must stay quiet
    if (stored[13:8] != 6'h3f) begin
      abort_run("Not every expected store to words 8 to 13 happened");
    end else begin
      $display("Simulation completed successfully");
      $finish;
    end
  end

endmodule

/* filelist.f */
+incdir+.
mips_pkg.sv
reg_file.sv
pc_reg.sv
control_decoder.sv
alu.sv
datapath.sv
mips_cpu.sv
tb_mips_cpu.sv

/* run_sim.sh */
#!/bin/sh
# build and run the mips core testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_mips_cpu \
  -f filelist.f -o sim_mips_cpu

# tee keeps the log even when the simulation exits with an error
./obj_dir/sim_mips_cpu 2>&1 | tee sim.log

if grep -q "Simulation failed" sim.log; then
  echo "run_sim: FAIL"
  exit 1
fi
echo "run_sim: PASS"
